// ==== hw/ptw_pkg.sv ====
// Sv39 only with 56-bit physical addresses; the memory read port carries one 64-bit PTE per beat
`default_nettype none

package ptw_pkg;

    // Address and page number widths for Sv39
    localparam int unsigned vlen = 39;
    localparam int unsigned plen = 56;
    localparam int unsigned ppn_w = 44;
    // PPN bits at or above this index must be zero
    localparam int unsigned gppn_w = 29;
    // VPN[2:0] as stored in the IOTLB
    localparam int unsigned vpn_w = 27;
    // Each table entry is 8 bytes wide
    localparam int unsigned pte_size_bytes = 8;

    // Page table entry, MSB first
    typedef struct packed {
        logic [9:0] reserved;
        logic [ppn_w-1:0] ppn;
        logic [1:0] rsw;
        logic d;
        logic a;
        logic g;
        logic u;
        logic x;
        logic w;
        logic r;
        logic v;
    } pte_t;

    // Walk level, lvl1 is the root table
    typedef enum logic [1:0] {
        lvl1,
        lvl2,
        lvl3
    } ptw_lvl_e;

    // Read request, address phase plus response ready
    typedef struct packed {
        logic ar_valid;
        logic [plen-1:0] ar_addr;
        logic r_ready;
    } mem_rd_req_t;

    // Read response from memory
    typedef struct packed {
        logic ar_ready;
        logic r_valid;
        pte_t r_data;
        logic r_err;
    } mem_rd_rsp_t;

    // One IOTLB fill
    typedef struct packed {
        logic valid;
        logic [vpn_w-1:0] vpn;
        logic is_2m;
        logic is_1g;
        pte_t content;
    } iotlb_update_t;

endpackage

`default_nettype wire

// ==== hw/iommu_cause_pkg.sv ====
// Only the first-stage page fault and data corruption causes are covered, no guest faults
`default_nettype none

package iommu_cause_pkg;

    localparam int unsigned cause_w = 12;

    typedef logic [cause_w-1:0] cause_t;

    // IOMMU fault record cause codes
    localparam cause_t load_page_fault = cause_t'(13);
    localparam cause_t store_page_fault = cause_t'(15);
    localparam cause_t pt_data_corruption = cause_t'(274);

    // Result of checking one fetched PTE
    typedef enum logic [1:0] {
        pte_ok_next,
        pte_ok_leaf,
        pte_fault
    } pte_verdict_e;

    // Error report at the end of a failed walk
    typedef struct packed {
        logic error;
        cause_t cause;
    } ptw_err_t;

endpackage

`default_nettype wire

// ==== hw/ptw_pte_check.sv ====
// Pure combinational PTE check; pte_i is only meaningful while the walker holds a live response
`timescale 1ns/1ps
`default_nettype none

module ptw_pte_check
    import ptw_pkg::*, iommu_cause_pkg::*;
(
    input  ptw_lvl_e     lvl_i,
    input  pte_t         pte_i,
    input  logic         is_store_i,
    output pte_verdict_e verdict_o
);

    logic is_leaf;
    logic bad_encoding;
    logic bad_high_bits;
    logic misaligned;
    logic leaf_perm_fault;
    logic pointer_fault;

    // R or X set marks a leaf, otherwise a pointer
    assign is_leaf = pte_i.r | pte_i.x;

    // Invalid, or write without read
    assign bad_encoding = ~pte_i.v | (~pte_i.r & pte_i.w);

    // Reserved bits set, or PPN beyond the addressable range
    assign bad_high_bits = (|pte_i.reserved) | (|pte_i.ppn[ppn_w-1:gppn_w]);

    // Superpage leaves need the lower PPN fields clear
    always_comb begin
        unique case (lvl_i)
            lvl1:    misaligned = |pte_i.ppn[17:0];
            lvl2:    misaligned = |pte_i.ppn[8:0];
            default: misaligned = 1'b0;
        endcase
    end

    // A must be set, R must be set, D must be set on a store
    assign leaf_perm_fault = ~pte_i.a | ~pte_i.r | (is_store_i & ~pte_i.d);

    // D, A, U are reserved on pointers, and lvl3 has no next table
    assign pointer_fault = pte_i.a | pte_i.d | pte_i.u | (lvl_i == lvl3);

    always_comb begin
        verdict_o = pte_fault;
        if (!bad_encoding && !bad_high_bits) begin
            if (is_leaf) begin
                if (!misaligned && !leaf_perm_fault) begin
                    verdict_o = pte_ok_leaf;
                end
            end else if (!pointer_fault) begin
                verdict_o = pte_ok_next;
            end
        end
    end

endmodule

`default_nettype wire

// ==== hw/ptw_walk_fsm.sv ====
// One walk at a time; is_store_i must be held for the whole walk, misses seen while busy are dropped
`timescale 1ns/1ps
`default_nettype none

module ptw_walk_fsm
    import ptw_pkg::*, iommu_cause_pkg::*;
(
    input  logic              clk_i,
    input  logic              rst_ni,
    input  logic              iotlb_access_i,
    input  logic              iotlb_hit_i,
    input  logic              en_1s_i,
    input  logic              is_store_i,
    input  logic [vlen-1:0]   req_iova_i,
    input  logic [ppn_w-1:0]  iosatp_ppn_i,
    output mem_rd_req_t       mem_req_o,
    input  mem_rd_rsp_t       mem_rsp_i,
    input  pte_verdict_e      verdict_i,
    output ptw_lvl_e          lvl_o,
    output logic              walk_start_o,
    output logic              pte_accept_o,
    output logic              leaf_done_o,
    output logic              ptw_active_o,
    output logic              bare_translation_o,
    output ptw_err_t          err_o
);

    localparam int unsigned page_off_w = 12;
    localparam int unsigned vpn_idx_w = 9;
    localparam int unsigned pte_shift = $clog2(pte_size_bytes);

    typedef enum logic [1:0] {
        idle,
        mem_access,
        pte_lookup,
        propagate_error
    } state_e;

    state_e state_q, state_n;
    ptw_lvl_e lvl_q, lvl_n;
    logic data_err_q, data_err_n;
    logic [plen-1:0] pptr_q, pptr_n;
    logic [vlen-1:0] iova_q, iova_n;

    logic miss;
    logic [vpn_idx_w-1:0] next_idx;

    // Table base plus index times entry size
    function automatic logic [plen-1:0] pte_addr(input logic [ppn_w-1:0] base,
                                                 input logic [vpn_idx_w-1:0] idx);
        return {base, {page_off_w{1'b0}}} | (plen'(idx) << pte_shift);
    endfunction

    assign miss = iotlb_access_i & ~iotlb_hit_i;

    // VPN[1] after the root, VPN[0] after lvl2
    assign next_idx = (lvl_q == lvl1) ? iova_q[29:21] : iova_q[20:12];

    assign lvl_o = lvl_q;
    assign ptw_active_o = (state_q != idle);

    always_comb begin
        state_n = state_q;
        lvl_n = lvl_q;
        data_err_n = data_err_q;
        pptr_n = pptr_q;
        iova_n = iova_q;

        // Read only port, address held from the pointer register
        mem_req_o.ar_valid = 1'b0;
        mem_req_o.ar_addr = pptr_q;
        mem_req_o.r_ready = 1'b0;

        walk_start_o = 1'b0;
        pte_accept_o = 1'b0;
        leaf_done_o = 1'b0;
        bare_translation_o = 1'b0;
        err_o.error = 1'b0;
        err_o.cause = '0;

        unique case (state_q)
            idle: begin
                if (miss) begin
                    if (en_1s_i) begin
                        // Root table from iosatp, indexed by VPN[2]
                        walk_start_o = 1'b1;
                        lvl_n = lvl1;
                        data_err_n = 1'b0;
                        iova_n = req_iova_i;
                        pptr_n = pte_addr(iosatp_ppn_i, req_iova_i[vlen-1:30]);
                        state_n = mem_access;
                    end else begin
                        // Translation off, nothing to fetch
                        bare_translation_o = 1'b1;
                    end
                end
            end

            mem_access: begin
                mem_req_o.ar_valid = 1'b1;
                if (mem_rsp_i.ar_ready) begin
                    state_n = pte_lookup;
                end
            end

            pte_lookup: begin
                // Take the response the cycle it shows up
                if (mem_rsp_i.r_valid) begin
                    mem_req_o.r_ready = 1'b1;
                    if (mem_rsp_i.r_err) begin
                        data_err_n = 1'b1;
                        state_n = propagate_error;
                    end else begin
                        pte_accept_o = 1'b1;
                        unique case (verdict_i)
                            pte_ok_next: begin
                                lvl_n = (lvl_q == lvl1) ? lvl2 : lvl3;
                                pptr_n = pte_addr(mem_rsp_i.r_data.ppn, next_idx);
                                state_n = mem_access;
                            end
                            pte_ok_leaf: begin
                                leaf_done_o = 1'b1;
                                state_n = idle;
                            end
                            default: begin
                                data_err_n = 1'b0;
                                state_n = propagate_error;
                            end
                        endcase
                    end
                end
            end

            propagate_error: begin
                err_o.error = 1'b1;
                if (data_err_q) begin
                    err_o.cause = pt_data_corruption;
                end else begin
                    err_o.cause = is_store_i ? store_page_fault : load_page_fault;
                end
                state_n = idle;
            end

            default: begin
                state_n = idle;
            end
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q <= idle;
            lvl_q <= lvl1;
            data_err_q <= 1'b0;
        end else begin
            state_q <= state_n;
            lvl_q <= lvl_n;
            data_err_q <= data_err_n;
        end
    end

    // Pointer and IOVA only matter while a walk runs
    always_ff @(posedge clk_i) begin
        pptr_q <= pptr_n;
        iova_q <= iova_n;
    end

endmodule

`default_nettype wire

// ==== hw/ptw_iotlb_update.sv ====
// Update content comes from the live response, so it is only valid in the leaf_done_i cycle
`timescale 1ns/1ps
`default_nettype none

module ptw_iotlb_update
    import ptw_pkg::*;
#(
    parameter int unsigned pscid_width = 20
) (
    input  logic                   clk_i,
    input  logic                   rst_ni,
    input  logic                   walk_start_i,
    input  logic                   pte_accept_i,
    input  logic                   leaf_done_i,
    input  ptw_lvl_e               lvl_i,
    input  logic [vlen-1:0]        req_iova_i,
    input  logic [pscid_width-1:0] pscid_i,
    input  pte_t                   pte_i,
    output iotlb_update_t          update_o,
    output logic [pscid_width-1:0] up_pscid_o
);

    logic global_q;
    logic [vpn_w-1:0] vpn_q;
    logic [pscid_width-1:0] pscid_q;
    pte_t leaf_pte;

    // Global accumulator, cleared per walk
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            global_q <= 1'b0;
        end else if (walk_start_i) begin
            global_q <= 1'b0;
        end else if (pte_accept_i) begin
            global_q <= global_q | pte_i.g;
        end
    end

    // Tags of the miss that started the walk
    always_ff @(posedge clk_i) begin
        if (walk_start_i) begin
            vpn_q <= req_iova_i[vlen-1:vlen-vpn_w];
            pscid_q <= pscid_i;
        end
    end

    // G from any upper level applies to the whole mapping
    always_comb begin
        leaf_pte = pte_i;
        leaf_pte.g = pte_i.g | global_q;
    end

    always_comb begin
        update_o.valid = leaf_done_i;
        update_o.vpn = vpn_q;
        // Leaf level gives the page size
        update_o.is_2m = (lvl_i == lvl2);
        update_o.is_1g = (lvl_i == lvl1);
        update_o.content = leaf_pte;
    end

    assign up_pscid_o = pscid_q;

endmodule

`default_nettype wire

// ==== hw/iommu_ptw_sv39.sv ====
// Single-stage Sv39 walker; no G-stage, no write channel, one outstanding read at a time
`timescale 1ns/1ps
`default_nettype none

module iommu_ptw_sv39
    import ptw_pkg::*, iommu_cause_pkg::*;
#(
    parameter int unsigned pscid_width = 20
) (
    input  logic                   clk_i,
    input  logic                   rst_ni,
    // Miss tags from the IOTLB and context
    input  logic                   iotlb_access_i,
    input  logic                   iotlb_hit_i,
    input  logic                   en_1s_i,
    input  logic                   is_store_i,
    input  logic [vlen-1:0]        req_iova_i,
    input  logic [pscid_width-1:0] pscid_i,
    input  logic [ppn_w-1:0]       iosatp_ppn_i,
    // Page table read port
    output mem_rd_req_t            mem_req_o,
    input  mem_rd_rsp_t            mem_rsp_i,
    // Walk results
    output logic                   ptw_active_o,
    output logic                   bare_translation_o,
    output ptw_err_t               err_o,
    output iotlb_update_t          update_o,
    output logic [pscid_width-1:0] up_pscid_o
);

    ptw_lvl_e lvl;
    pte_verdict_e verdict;
    logic walk_start;
    logic pte_accept;
    logic leaf_done;

    ptw_walk_fsm fsm_i (
        .clk_i              (clk_i),
        .rst_ni             (rst_ni),
        .iotlb_access_i     (iotlb_access_i),
        .iotlb_hit_i        (iotlb_hit_i),
        .en_1s_i            (en_1s_i),
        .is_store_i         (is_store_i),
        .req_iova_i         (req_iova_i),
        .iosatp_ppn_i       (iosatp_ppn_i),
        .mem_req_o          (mem_req_o),
        .mem_rsp_i          (mem_rsp_i),
        .verdict_i          (verdict),
        .lvl_o              (lvl),
        .walk_start_o       (walk_start),
        .pte_accept_o       (pte_accept),
        .leaf_done_o        (leaf_done),
        .ptw_active_o       (ptw_active_o),
        .bare_translation_o (bare_translation_o),
        .err_o              (err_o)
    );

    // Checks the entry currently on the response bus
    ptw_pte_check check_i (
        .lvl_i      (lvl),
        .pte_i      (mem_rsp_i.r_data),
        .is_store_i (is_store_i),
        .verdict_o  (verdict)
    );

    ptw_iotlb_update #(
        .pscid_width (pscid_width)
    ) update_i (
        .clk_i        (clk_i),
        .rst_ni       (rst_ni),
        .walk_start_i (walk_start),
        .pte_accept_i (pte_accept),
        .leaf_done_i  (leaf_done),
        .lvl_i        (lvl),
        .req_iova_i   (req_iova_i),
        .pscid_i      (pscid_i),
        .pte_i        (mem_rsp_i.r_data),
        .update_o     (update_o),
        .up_pscid_o   (up_pscid_o)
    );

endmodule

`default_nettype wire

// ==== testbench/tb_iommu_ptw.sv ====
// Reads testbench/ptw_stim.txt from the project root; unmapped addresses read as an all-zero PTE
`timescale 1ns/1ps
`default_nettype none

module tb_iommu_ptw
    import ptw_pkg::*, iommu_cause_pkg::*;
;

    localparam int unsigned pscid_width = 20;
    localparam int unsigned stim_depth = 512;
    // Stim rows are 8 words, word 0 gives the row kind
    localparam int unsigned row_words = 8;
    localparam int unsigned row_end = 0;
    localparam int unsigned row_mem = 1;
    localparam int unsigned row_req = 2;
    // Result kinds in request rows
    localparam int unsigned res_update = 1;
    localparam int unsigned res_error = 2;
    localparam int unsigned res_bare = 3;
    localparam logic [ppn_w-1:0] root_ppn = ppn_w'('h100);

    logic clk_i;
    logic rst_ni;
    logic iotlb_access_i;
    logic iotlb_hit_i;
    logic en_1s_i;
    logic is_store_i;
    logic [vlen-1:0] req_iova_i;
    logic [pscid_width-1:0] pscid_i;
    logic [ppn_w-1:0] iosatp_ppn_i;
    mem_rd_req_t mem_req;
    mem_rd_rsp_t mem_rsp;
    logic ptw_active_o;
    logic bare_translation_o;
    ptw_err_t err_o;
    iotlb_update_t update_o;
    logic [pscid_width-1:0] up_pscid_o;

    logic [63:0] stim_words [0:stim_depth-1];
    // Sparse page table and the addresses that answer with r_err
    pte_t mem_table [logic [plen-1:0]];
    bit bad_table [logic [plen-1:0]];
    int unsigned req_base [$];
    int unsigned cycles = 0;
    int unsigned cycle_limit = 100;

    iommu_ptw_sv39 #(
        .pscid_width (pscid_width)
    ) dut_i (
        .clk_i              (clk_i),
        .rst_ni             (rst_ni),
        .iotlb_access_i     (iotlb_access_i),
        .iotlb_hit_i        (iotlb_hit_i),
        .en_1s_i            (en_1s_i),
        .is_store_i         (is_store_i),
        .req_iova_i         (req_iova_i),
        .pscid_i            (pscid_i),
        .iosatp_ppn_i       (iosatp_ppn_i),
        .mem_req_o          (mem_req),
        .mem_rsp_i          (mem_rsp),
        .ptw_active_o       (ptw_active_o),
        .bare_translation_o (bare_translation_o),
        .err_o              (err_o),
        .update_o           (update_o),
        .up_pscid_o         (up_pscid_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #50 clk_i = ~clk_i;
    end

    // Run length guard, limit set once the stimulus is loaded
    always @(posedge clk_i) begin
        cycles = cycles + 1;
        if (cycles > cycle_limit) begin
            abort_run($sformatf("Timeout after %0d cycles, the walker gave no result", cycles));
        end
    end

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Finished with errors");
        $fatal(1);
    endtask

    task automatic load_stimulus();
        int unsigned i;
        for (i = 0; i < stim_depth; i++) begin
            stim_words[i] = '0;
        end
        $readmemh("testbench/ptw_stim.txt", stim_words);
        // Walk rows until the end marker
        for (i = 0; i + row_words <= stim_depth; i += row_words) begin
            if (stim_words[i] == row_end) begin
                break;
            end else if (stim_words[i] == row_mem) begin
                mem_table[stim_words[i+1][plen-1:0]] = pte_t'(stim_words[i+2]);
                if (stim_words[i+3][0]) begin
                    bad_table[stim_words[i+1][plen-1:0]] = 1'b1;
                end
            end else if (stim_words[i] == row_req) begin
                req_base.push_back(i);
            end
        end
    endtask

    // Read port model, random ar_ready and r_valid delays of 0 to 3 cycles
    task automatic serve_memory();
        logic [plen-1:0] rd_addr;
        int unsigned wait_cnt;
        bit pending;
        pending = 1'b0;
        wait_cnt = 0;
        rd_addr = '0;
        forever begin
            @(posedge clk_i);
            if (!rst_ni) begin
                mem_rsp <= '0;
                pending = 1'b0;
                wait_cnt = $urandom % 4;
            end else if (!pending) begin
                if (mem_req.ar_valid && mem_rsp.ar_ready) begin
                    // Address accepted, now schedule the response
                    mem_rsp.ar_ready <= 1'b0;
                    rd_addr = mem_req.ar_addr;
                    pending = 1'b1;
                    wait_cnt = $urandom % 4;
                end else if (mem_req.ar_valid) begin
                    if (wait_cnt == 0) begin
                        mem_rsp.ar_ready <= 1'b1;
                    end else begin
                        wait_cnt = wait_cnt - 1;
                    end
                end
            end else if (mem_rsp.r_valid && mem_req.r_ready) begin
                mem_rsp.r_valid <= 1'b0;
                pending = 1'b0;
                wait_cnt = $urandom % 4;
            end else if (!mem_rsp.r_valid) begin
                if (wait_cnt == 0) begin
                    mem_rsp.r_valid <= 1'b1;
                    mem_rsp.r_data <= mem_table.exists(rd_addr) ? mem_table[rd_addr] : '0;
                    mem_rsp.r_err <= bad_table.exists(rd_addr);
                end else begin
                    wait_cnt = wait_cnt - 1;
                end
            end
        end
    endtask

    task automatic check_update(input iotlb_update_t got, input logic [pscid_width-1:0] got_pscid,
                                input iotlb_update_t exp, input logic [pscid_width-1:0] exp_pscid);
        if (got !== exp) begin
            abort_run($sformatf({"Mismatch at %0t: update vpn %h 1g %b 2m %b pte %h, ",
                                 "expected vpn %h 1g %b 2m %b pte %h"}, $time,
                                got.vpn, got.is_1g, got.is_2m, got.content,
                                exp.vpn, exp.is_1g, exp.is_2m, exp.content));
        end else if (got_pscid !== exp_pscid) begin
            abort_run($sformatf("Mismatch at %0t: update pscid %h, expected %h",
                                $time, got_pscid, exp_pscid));
        end
    endtask

    task automatic check_err(input ptw_err_t got, input ptw_err_t exp);
        if (got !== exp) begin
            abort_run($sformatf("Mismatch at %0t: error %b cause %0d, expected error %b cause %0d",
                                $time, got.error, got.cause, exp.error, exp.cause));
        end
    endtask

    // Bare translation must come without a read or an IOTLB fill
    task automatic check_bare(input logic got_bare, input mem_rd_req_t got_req,
                              input iotlb_update_t got_upd);
        if (got_bare !== 1'b1 || got_req.ar_valid !== 1'b0 || got_upd.valid !== 1'b0) begin
            abort_run($sformatf("Mismatch at %0t: bare %b ar_valid %b update %b, expected 1 0 0",
                                $time, got_bare, got_req.ar_valid, got_upd.valid));
        end
    endtask

    task automatic check_active(input logic got_active, input logic exp_active);
        if (got_active !== exp_active) begin
            abort_run($sformatf("Mismatch at %0t: ptw_active %b, expected %b",
                                $time, got_active, exp_active));
        end
    endtask

    task automatic run_request(input int unsigned n);
        int unsigned base;
        int unsigned got_kind;
        int unsigned exp_kind;
        int unsigned edges;
        iotlb_update_t got_upd;
        iotlb_update_t exp_upd;
        ptw_err_t got_err;
        ptw_err_t exp_err;
        logic [pscid_width-1:0] got_pscid;
        logic got_bare;
        logic got_active;
        mem_rd_req_t got_req;
        base = req_base[n];
        exp_kind = stim_words[base+4];
        @(posedge clk_i);
        iotlb_access_i <= 1'b1;
        iotlb_hit_i <= 1'b0;
        en_1s_i <= stim_words[base+1][0];
        is_store_i <= stim_words[base+1][1];
        req_iova_i <= stim_words[base+2][vlen-1:0];
        pscid_i <= stim_words[base+3][pscid_width-1:0];
        got_kind = 0;
        edges = 0;
        // Sample at each edge, the miss is only offered for one cycle
        while (got_kind == 0) begin
            @(posedge clk_i);
            iotlb_access_i <= 1'b0;
            edges = edges + 1;
            got_upd = update_o;
            got_pscid = up_pscid_o;
            got_err = err_o;
            got_bare = bare_translation_o;
            got_req = mem_req;
            got_active = ptw_active_o;
            // Busy from the cycle after the miss up to the result
            if (edges > 1) begin
                check_active(got_active, 1'b1);
            end
            if (got_upd.valid) begin
                got_kind = res_update;
            end else if (got_err.error) begin
                got_kind = res_error;
            end else if (got_bare) begin
                got_kind = res_bare;
            end
        end
        if (got_kind != exp_kind) begin
            abort_run($sformatf("Request %0d ended with result kind %0d instead of kind %0d",
                                n, got_kind, exp_kind));
        end else if (exp_kind == res_update) begin
            exp_upd.valid = 1'b1;
            exp_upd.is_2m = stim_words[base+5][0];
            exp_upd.is_1g = stim_words[base+5][1];
            exp_upd.vpn = stim_words[base+6][vpn_w-1:0];
            exp_upd.content = pte_t'(stim_words[base+7]);
            check_update(got_upd, got_pscid, exp_upd, stim_words[base+3][pscid_width-1:0]);
        end else if (exp_kind == res_error) begin
            exp_err.error = 1'b1;
            exp_err.cause = cause_t'(stim_words[base+5]);
            check_err(got_err, exp_err);
        end else begin
            check_bare(got_bare, got_req, got_upd);
        end
        // Back in IDLE one cycle after any result, so a bare miss started no walk
        @(posedge clk_i);
        check_active(ptw_active_o, 1'b0);
    endtask

    initial begin
        rst_ni = 1'b0;
        iotlb_access_i = 1'b0;
        iotlb_hit_i = 1'b0;
        en_1s_i = 1'b0;
        is_store_i = 1'b0;
        req_iova_i = '0;
        pscid_i = '0;
        iosatp_ppn_i = root_ppn;
        mem_rsp = '0;
        void'($urandom(32'ha349));
        load_stimulus();
        // Three levels at up to ten cycles each, plus slack
        cycle_limit = req_base.size() * 3 * 10 + 100;
        fork
            serve_memory();
        join_none
        repeat (2) @(posedge clk_i);
        rst_ni <= 1'b1;
        for (int unsigned n = 0; n < req_base.size(); n++) begin
            run_request(n);
        end
        $display("Finished with no errors");
        $finish;
    end

endmodule

`default_nettype wire

// ==== list.f ====
hw/ptw_pkg.sv
hw/iommu_cause_pkg.sv
hw/ptw_pte_check.sv
hw/ptw_walk_fsm.sv
hw/ptw_iotlb_update.sv
hw/iommu_ptw_sv39.sv
testbench/tb_iommu_ptw.sv

// ==== testbench/ptw_stim.txt ====
// Rows of 8 hex words; word 0 is the row kind (1 memory, 2 request, 0 end of data)
// Memory: addr pte bad. Request: ctrl(b0 en_1s, b1 store) iova pscid result exp_a exp_b exp_c
// Results are 1 update (exp_a b0 2m b1 1g, exp_b vpn, exp_c pte), 2 error (exp_a cause), 3 bare
1 100008 80001 0 0 0 0 0
1 200010 80401 0 0 0 0 0
1 201018 48D14CF 0 0 0 0 0
1 100010 84001 0 0 0 0 0
1 210028 1000CF 0 0 0 0 0
1 100018 100000CF 0 0 0 0 0
1 100020 88021 0 0 0 0 0
1 220008 88401 0 0 0 0 0
1 221038 1554CF 0 0 0 0 0
1 100028 CE 0 0 0 0 0
1 100030 100004CF 0 0 0 0 0
1 100038 2000008F 0 0 0 0 0
1 100040 3000004F 0 0 0 0 0
1 100048 88041 0 0 0 0 0
1 100050 8C001 0 0 0 0 0
1 230000 8C401 0 0 0 0 0
1 231000 8C801 0 0 0 0 0
1 100058 90001 0 0 0 0 0
1 240000 0 1 0 0 0 0
// 4K, 2M, 1G walks and a global bit taken from the root pointer
2 1 40403000 0A 1 0 40403 48D14CF
2 3 80A00000 0B 1 1 80A00 1000CF
2 1 C0000000 0C 1 2 C0000 100000CF
2 1 100207000 0D 1 0 100207 1554EF
// Invalid, misaligned 1G, A clear, store with D clear, pointer with A, pointer at level three
2 3 140000000 0E 2 F 0 0
2 1 180000000 0F 2 D 0 0
2 1 1C0000000 10 2 D 0 0
2 3 200000000 11 2 F 0 0
2 1 240000000 12 2 D 0 0
2 3 280000000 13 2 F 0 0
// Bus error on the second level read, then translation off
2 1 2C0000000 14 2 112 0 0
2 0 12345000 15 3 0 0 0
0 0 0 0 0 0 0 0
